/* source/vlsu_params.svh */
`ifndef VLSU_PARAMS_SVH
`define VLSU_PARAMS_SVH

// Vector register geometry
`define VLSU_VLEN  64
`define VLSU_VLENB 8

// Memory port geometry
`define VLSU_XLEN       32
`define VLSU_WORD_BYTES 4

// Element indices and vl run from 0 to VLENB inclusive
`define VLSU_IDX_W 4

`endif

/* source/vlsu_pkg.sv */
`default_nettype none

`include "vlsu_params.svh"

package vlsu_pkg;

    typedef enum logic [1:0] {
        IDLE,
        FIRST,
        EXEC,
        LAST
    } vlsu_state_e;

    // Encoding doubles as log2 of the element size in bytes
    typedef enum logic [1:0] {
        EW8,
        EW16,
        EW32
    } elem_width_e;

    typedef enum logic {
        UNIT_STRIDED,
        STRIDED
    } addr_mode_e;

    typedef struct packed {
        logic        is_store;
        addr_mode_e  mode;
        elem_width_e width;
    } vlsu_cmd_t;

    typedef struct packed {
        logic                   active;
        logic                   first;
        logic                   last;
        logic [`VLSU_IDX_W-1:0] elem_index;
        logic [2:0]             elem_count;
        logic [1:0]             byte_lane;
    } vlsu_beat_t;

    // One memory word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [`VLSU_WORD_BYTES-1:0][7:0]    bytes;
        logic [`VLSU_WORD_BYTES/2-1:0][15:0] halves;
    } mem_word_u;

endpackage

`default_nettype wire

/* source/vlsu_sequencer.sv */
`default_nettype none
`timescale 1ns/10ps

`include "vlsu_params.svh"

module vlsu_sequencer (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start_i,
    input  logic [`VLSU_XLEN-1:0]  instr_i,
    input  logic [`VLSU_XLEN-1:0]  base_address_i,
    input  logic [`VLSU_XLEN-1:0]  stride_i,
    output vlsu_pkg::vlsu_cmd_t    cmd_o,
    output vlsu_pkg::vlsu_beat_t   beat_o,
    output logic [`VLSU_XLEN-1:0]  mem_address_o,
    output logic                   hold_o
);
    import vlsu_pkg::*;

    vlsu_state_e            state;
    vlsu_state_e            next_state;
    elem_width_e            width;
    addr_mode_e             mode;
    logic [`VLSU_IDX_W-1:0] elems_per_reg;
    logic [`VLSU_IDX_W-1:0] elems_done;
    logic [`VLSU_IDX_W-1:0] elems_next;
    logic [`VLSU_IDX_W-1:0] remaining;
    logic [2:0]             full_beat;
    logic [2:0]             first_count;
    logic [2:0]             beat_count;
    logic [`VLSU_XLEN-1:0]  offset;
    logic [`VLSU_XLEN-1:0]  address;
    logic [1:0]             byte_lane;
    logic                   next_is_last;
    logic                   busy_r;

    //////////////////////////////
    // Decode
    //////////////////////////////

    always_comb begin
        case (instr_i[14:12])
            3'b000:  width = EW8;
            3'b101:  width = EW16;
            default: width = EW32;
        endcase
    end

    // Indexed encodings fall back to strided
    assign mode  = (instr_i[27:26] == 2'b00) ? UNIT_STRIDED : STRIDED;
    assign cmd_o = '{is_store: instr_i[5], mode: mode, width: width};

    assign elems_per_reg = (`VLSU_IDX_W)'(`VLSU_VLENB >> width);

    //////////////////////////////
    // Element counting
    //////////////////////////////

    // Elements in a full word beat
    assign full_beat   = (mode == STRIDED) ? 3'd1 : 3'((`VLSU_WORD_BYTES) >> width);
    assign first_count = 3'((`VLSU_WORD_BYTES - base_address_i[1:0]) >> width);
    assign remaining   = elems_per_reg - elems_done;

    always_comb begin
        if (mode == STRIDED)
            beat_count = 3'd1;
        else if (state == FIRST)
            beat_count = first_count;
        else if (state == LAST)
            beat_count = remaining[2:0];
        else
            beat_count = full_beat;
    end

    assign elems_next   = (state == IDLE || state == LAST)
                          ? '0
                          : elems_done + (`VLSU_IDX_W)'(beat_count);
    // Last beat once what is left fits in one full beat
    assign next_is_last = (elems_per_reg - elems_next) <= (`VLSU_IDX_W)'(full_beat);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            elems_done <= '0;
        else
            elems_done <= elems_next;
    end

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        case (state)
            IDLE:    next_state = start_i ? FIRST : IDLE;
            FIRST:   next_state = next_is_last ? LAST : EXEC;
            EXEC:    next_state = next_is_last ? LAST : EXEC;
            default: next_state = IDLE;
        endcase
    end

    //////////////////////////////
    // Address
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            offset <= '0;
        else if (state == IDLE || state == LAST)
            offset <= '0;
        else if (mode == UNIT_STRIDED)
            offset <= offset + `VLSU_WORD_BYTES;
        else
            offset <= offset + stride_i;
    end

    assign address       = base_address_i + offset;
    assign mem_address_o = address;

    // Unit-strided beats after the first start at lane 0
    assign byte_lane = (mode == UNIT_STRIDED && state != FIRST) ? 2'b00 : address[1:0];

    assign beat_o = '{
        active:     state != IDLE,
        first:      state == FIRST,
        last:       state == LAST,
        elem_index: elems_done,
        elem_count: beat_count,
        byte_lane:  byte_lane
    };

    //////////////////////////////
    // Hold
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            busy_r <= 1'b0;
        else
            busy_r <= (state != IDLE);
    end

    // Loads stay busy one extra cycle for the returning word
    assign hold_o = cmd_o.is_store
                    ? (state == FIRST || state == EXEC)
                    : (state != IDLE || busy_r);

endmodule

`default_nettype wire

/* source/vlsu_store_lane.sv */
`default_nettype none
`timescale 1ns/10ps

`include "vlsu_params.svh"

module vlsu_store_lane (
    input  vlsu_pkg::vlsu_cmd_t            cmd_i,
    input  vlsu_pkg::vlsu_beat_t           beat_i,
    input  logic [`VLSU_IDX_W-1:0]         vl_i,
    input  logic                           vm_i,
    input  logic [`VLSU_VLENB-1:0]         mask_i,
    input  logic [`VLSU_VLEN-1:0]          write_data_i,
    output logic [`VLSU_WORD_BYTES-1:0]    mem_write_enable_o,
    output logic [`VLSU_XLEN-1:0]          mem_write_data_o
);
    import vlsu_pkg::*;

    logic [1:0]             first_slot;
    logic [`VLSU_IDX_W-1:0] slot_elem [`VLSU_WORD_BYTES];
    mem_word_u              lane_word;

    // Slot of the first element in units of the element width
    assign first_slot = beat_i.byte_lane >> cmd_i.width;

    //////////////////////////////
    // Element per slot
    //////////////////////////////

    // A strided beat repeats one element in every slot
    always_comb begin
        for (int s = 0; s < `VLSU_WORD_BYTES; s++) begin
            if (cmd_i.mode == STRIDED)
                slot_elem[s] = beat_i.elem_index;
            else
                slot_elem[s] = beat_i.elem_index + (`VLSU_IDX_W)'(s)
                               - (`VLSU_IDX_W)'(first_slot);
        end
    end

    //////////////////////////////
    // Write data
    //////////////////////////////

    always_comb begin
        case (cmd_i.width)
            EW8: begin
                for (int p = 0; p < `VLSU_WORD_BYTES; p++)
                    lane_word.bytes[p] = write_data_i[8*slot_elem[p][2:0] +: 8];
            end
            EW16: begin
                for (int p = 0; p < `VLSU_WORD_BYTES/2; p++)
                    lane_word.halves[p] = write_data_i[16*slot_elem[p][1:0] +: 16];
            end
            default: begin
                lane_word = write_data_i[32*slot_elem[0][0] +: 32];
            end
        endcase
    end

    assign mem_write_data_o = lane_word;

    //////////////////////////////
    // Byte enables
    //////////////////////////////

    always_comb begin
        logic [1:0]             lane;
        logic [1:0]             slot;
        logic [`VLSU_IDX_W-1:0] elem;
        for (int l = 0; l < `VLSU_WORD_BYTES; l++) begin
            lane = 2'(l);
            slot = lane >> cmd_i.width;
            elem = slot_elem[slot];
            // Lane inside the beat, below vl, and not masked off
            mem_write_enable_o[l] = cmd_i.is_store && beat_i.active
                && (lane >= beat_i.byte_lane)
                && (((lane - beat_i.byte_lane) >> cmd_i.width) < beat_i.elem_count)
                && (elem < vl_i)
                && (vm_i || mask_i[elem[2:0]]);
        end
    end

endmodule

`default_nettype wire

/* source/vlsu_load_merge.sv */
`default_nettype none
`timescale 1ns/10ps

`include "vlsu_params.svh"

module vlsu_load_merge (
    input  logic                   clk,
    input  logic                   reset_n,
    input  vlsu_pkg::vlsu_cmd_t    cmd_i,
    input  vlsu_pkg::vlsu_beat_t   beat_i,
    input  logic [`VLSU_XLEN-1:0]  mem_read_data_i,
    output logic [`VLSU_VLEN-1:0]  read_data_o
);
    import vlsu_pkg::*;

    vlsu_cmd_t              cmd_r;
    vlsu_beat_t             beat_r;
    mem_word_u              read_word;
    logic [1:0]             first_slot;
    logic [`VLSU_VLEN-1:0]  merged;

    //////////////////////////////
    // Stage barrier
    //////////////////////////////

    // Beat issued last cycle matches the word now on the read port
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmd_r  <= '0;
            beat_r <= '0;
        end else begin
            cmd_r  <= cmd_i;
            beat_r <= beat_i;
        end
    end

    //////////////////////////////
    // Merge
    //////////////////////////////

    assign read_word  = mem_read_data_i;
    assign first_slot = beat_r.byte_lane >> cmd_r.width;

    always_comb begin
        logic [1:0]             src;
        logic [`VLSU_IDX_W-1:0] dst;
        // Fresh accumulator on the first beat
        merged = beat_r.first ? '0 : read_data_o;
        for (int s = 0; s < `VLSU_WORD_BYTES; s++) begin
            src = first_slot + 2'(s);
            dst = beat_r.elem_index + (`VLSU_IDX_W)'(s);
            if (s < beat_r.elem_count) begin
                case (cmd_r.width)
                    EW8:     merged[8*dst[2:0] +: 8]   = read_word.bytes[src];
                    EW16:    merged[16*dst[1:0] +: 16] = read_word.halves[src[0]];
                    default: merged[32*dst[0] +: 32]   = read_word;
                endcase
            end
        end
    end

    // Stores leave the result untouched
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            read_data_o <= '0;
        else if (beat_r.active && !cmd_r.is_store)
            read_data_o <= merged;
    end

endmodule

`default_nettype wire

/* source/vector_lsu.sv */
`default_nettype none
`timescale 1ns/10ps

`include "vlsu_params.svh"

module vector_lsu (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  logic [`VLSU_XLEN-1:0]         instr_i,
    input  logic [`VLSU_XLEN-1:0]         base_address_i,
    input  logic [`VLSU_XLEN-1:0]         stride_i,
    input  logic [`VLSU_IDX_W-1:0]        vl_i,
    input  logic                          vm_i,
    input  logic [`VLSU_VLENB-1:0]        mask_i,
    input  logic [`VLSU_VLEN-1:0]         write_data_i,
    output logic                          hold_o,
    output logic [`VLSU_XLEN-1:0]         mem_address_o,
    output logic [`VLSU_WORD_BYTES-1:0]   mem_write_enable_o,
    output logic [`VLSU_XLEN-1:0]         mem_write_data_o,
    input  logic [`VLSU_XLEN-1:0]         mem_read_data_i,
    output logic [`VLSU_VLEN-1:0]         read_data_o
);
    import vlsu_pkg::*;

    vlsu_cmd_t  cmd;
    vlsu_beat_t beat;

    // Address and beat generation in stage 1
    vlsu_sequencer sequencer_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start_i),
        .instr_i        (instr_i),
        .base_address_i (base_address_i),
        .stride_i       (stride_i),
        .cmd_o          (cmd),
        .beat_o         (beat),
        .mem_address_o  (mem_address_o),
        .hold_o         (hold_o)
    );

    // Write side of stage 1
    vlsu_store_lane store_lane_i (
        .cmd_i              (cmd),
        .beat_i             (beat),
        .vl_i               (vl_i),
        .vm_i               (vm_i),
        .mask_i             (mask_i),
        .write_data_i       (write_data_i),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    // Read merge in stage 2
    vlsu_load_merge load_merge_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .cmd_i           (cmd),
        .beat_i          (beat),
        .mem_read_data_i (mem_read_data_i),
        .read_data_o     (read_data_o)
    );

endmodule

`default_nettype wire

/* verification/tb_vlsu_memory.sv */
`default_nettype none
`timescale 1ns/10ps

`include "vlsu_params.svh"

module tb_vlsu_memory #(
    parameter int BYTES = 256
) (
    input  logic                         clk,
    input  logic [`VLSU_XLEN-1:0]        address_i,
    input  logic [`VLSU_WORD_BYTES-1:0]  write_enable_i,
    input  logic [`VLSU_XLEN-1:0]        write_data_i,
    output logic [`VLSU_XLEN-1:0]        read_data_o
);

    localparam int WORD_AW = $clog2(BYTES / `VLSU_WORD_BYTES);

    logic [7:0]         mem [BYTES];
    logic [WORD_AW-1:0] word;
    logic [WORD_AW-1:0] read_word_q;

    // Bits 1:0 of the byte address are dropped and upper bits wrap
    assign word = address_i[WORD_AW+1:2];

    always @(posedge clk) begin
        for (int b = 0; b < `VLSU_WORD_BYTES; b++) begin
            if (write_enable_i[b])
                mem[{word, 2'(b)}] <= write_data_i[8*b +: 8];
        end
        read_word_q <= word;
    end

    // Word at the address presented in the previous cycle
    assign read_data_o = {mem[{read_word_q, 2'd3}], mem[{read_word_q, 2'd2}],
                          mem[{read_word_q, 2'd1}], mem[{read_word_q, 2'd0}]};

endmodule

`default_nettype wire

/* verification/tb_vector_lsu.sv */
`default_nettype none
`timescale 1ns/10ps

`include "vlsu_params.svh"

module tb_vector_lsu;

    localparam int NUM_OPS        = 200;
    localparam int RESET_CYCLES   = 10;
    localparam int OP_CYCLES      = 20;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_OPS * OP_CYCLES;
    localparam int MEM_BYTES      = 256;

    logic                          clk;
    logic                          reset_n;
    logic                          start;
    logic [`VLSU_XLEN-1:0]         instr;
    logic [`VLSU_XLEN-1:0]         base_address;
    logic [`VLSU_XLEN-1:0]         stride;
    logic [`VLSU_IDX_W-1:0]        vl;
    logic                          vm;
    logic [`VLSU_VLENB-1:0]        mask;
    logic [`VLSU_VLEN-1:0]         write_data;
    logic                          hold;
    logic [`VLSU_XLEN-1:0]         mem_address;
    logic [`VLSU_WORD_BYTES-1:0]   mem_write_enable;
    logic [`VLSU_XLEN-1:0]         mem_write_data;
    logic [`VLSU_XLEN-1:0]         mem_read_data;
    logic [`VLSU_VLEN-1:0]         read_data;

    // Current operation
    logic                          op_store;
    logic                          op_strided;
    logic                          op_vm;
    logic [`VLSU_VLENB-1:0]        op_mask;
    logic [`VLSU_VLEN-1:0]         op_data;
    logic [`VLSU_XLEN-1:0]         op_instr;
    int                            op_wbytes;
    int                            op_base;
    int                            op_stride;
    int                            op_vl;

    logic [7:0]                    shadow [MEM_BYTES];
    logic [`VLSU_VLEN-1:0]         last_load;
    logic [15:0]                   lfsr;
    int                            cycle_count;
    int                            reset_errors;
    int                            hold_errors;
    int                            load_errors;
    int                            store_errors;

    vector_lsu vector_lsu_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .start_i            (start),
        .instr_i            (instr),
        .base_address_i     (base_address),
        .stride_i           (stride),
        .vl_i               (vl),
        .vm_i               (vm),
        .mask_i             (mask),
        .write_data_i       (write_data),
        .hold_o             (hold),
        .mem_address_o      (mem_address),
        .mem_write_enable_o (mem_write_enable),
        .mem_write_data_o   (mem_write_data),
        .mem_read_data_i    (mem_read_data),
        .read_data_o        (read_data)
    );

    tb_vlsu_memory #(.BYTES(MEM_BYTES)) memory_i (
        .clk            (clk),
        .address_i      (mem_address),
        .write_enable_i (mem_write_enable),
        .write_data_i   (mem_write_data),
        .read_data_o    (mem_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: operations did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////
    // Random numbers
    //////////////////////////////

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic pick_op();
        logic [1:0] mfield;
        logic [2:0] wfield;
        int         wsel;
        op_store   = 1'(take_bits(1));
        op_strided = 1'(take_bits(1));
        wsel       = int'(take_bits(2) % 3);
        op_wbytes  = 1 << wsel;
        op_base    = int'(take_bits(8) % 201);
        op_base    = op_base - (op_base % op_wbytes);
        op_stride  = (int'(take_bits(3)) + 1) * op_wbytes;
        op_vl      = int'(take_bits(4) % 9);
        op_vm      = 1'(take_bits(1));
        op_mask    = 8'(take_bits(8));
        op_data    = take_bits(64);
        // Indexed encodings behave as strided
        if (op_strided) begin
            mfield = 2'(take_bits(2));
            if (mfield == 2'b00)
                mfield = 2'b10;
        end else begin
            mfield = 2'b00;
        end
        case (wsel)
            0:       wfield = 3'b000;
            1:       wfield = 3'b101;
            default: wfield = 3'b110 | 3'(take_bits(1));
        endcase
        op_instr        = '0;
        op_instr[6:0]   = op_store ? 7'h27 : 7'h07;
        op_instr[14:12] = wfield;
        op_instr[25]    = op_vm;
        op_instr[27:26] = mfield;
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic int expected_beats();
        if (op_strided)
            return `VLSU_VLENB / op_wbytes;
        return ((op_base % `VLSU_WORD_BYTES) + `VLSU_VLENB + `VLSU_WORD_BYTES - 1)
               / `VLSU_WORD_BYTES;
    endfunction

    function automatic int elem_addr(input int e);
        if (op_strided)
            return (op_base + e * op_stride) % MEM_BYTES;
        return (op_base + e * op_wbytes) % MEM_BYTES;
    endfunction

    // Loads fill the whole register regardless of vl and mask
    function automatic logic [63:0] predict_load();
        logic [63:0] r;
        r = '0;
        for (int e = 0; e < `VLSU_VLENB / op_wbytes; e++)
            for (int b = 0; b < op_wbytes; b++)
                r[8*(e*op_wbytes+b) +: 8] = shadow[(elem_addr(e) + b) % MEM_BYTES];
        return r;
    endfunction

    task automatic apply_store();
        for (int e = 0; e < `VLSU_VLENB / op_wbytes; e++) begin
            if (e < op_vl && (op_vm || op_mask[e])) begin
                for (int b = 0; b < op_wbytes; b++)
                    shadow[(elem_addr(e) + b) % MEM_BYTES] = op_data[8*(e*op_wbytes+b) +: 8];
            end
        end
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic report_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        $display("Fail %s expected %h got %h", name, expected, actual);
    endtask

    task automatic check_memory();
        for (int i = 0; i < MEM_BYTES; i++) begin
            assert (memory_i.mem[i] === shadow[i]) else begin
                $display("Fail mem[%02h] expected %02h got %02h", i, shadow[i], memory_i.mem[i]);
                store_errors++;
            end
        end
    endtask

    task automatic run_op();
        int          hold_cycles;
        int          want_hold;
        logic [63:0] want_data;
        want_hold = op_store ? expected_beats() - 1 : expected_beats() + 1;
        @(posedge clk);
        #5;
        instr        = op_instr;
        base_address = op_base;
        stride       = op_stride;
        vl           = 4'(op_vl);
        vm           = op_vm;
        mask         = op_mask;
        write_data   = op_data;
        start        = 1'b1;
        @(posedge clk);
        #5;
        start       = 1'b0;
        hold_cycles = 0;
        while (hold) begin
            hold_cycles++;
            @(posedge clk);
            #5;
        end
        assert (hold_cycles == want_hold) else begin
            report_value("hold_o cycles", want_hold, hold_cycles);
            hold_errors++;
        end
        if (op_store) begin
            // Last beat writes at the next edge
            @(posedge clk);
            #5;
            apply_store();
            check_memory();
            // Result of the last load stays in place across a store
            assert (read_data === last_load) else begin
                report_value("read_data_o", last_load, read_data);
                store_errors++;
            end
        end else begin
            want_data = predict_load();
            assert (read_data === want_data) else begin
                report_value("read_data_o", want_data, read_data);
                load_errors++;
            end
            last_load = want_data;
            // A load leaves memory unchanged
            check_memory();
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        lfsr         = 16'd44;
        reset_n      = 1'b0;
        start        = 1'b0;
        instr        = '0;
        base_address = '0;
        stride       = '0;
        vl           = '0;
        vm           = 1'b0;
        mask         = '0;
        write_data   = '0;
        last_load    = '0;
        reset_errors = 0;
        hold_errors  = 0;
        load_errors  = 0;
        store_errors = 0;

        // Random memory image mirrored in the shadow
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i]       = 8'(take_bits(8));
            memory_i.mem[i] = shadow[i];
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        assert (hold === 1'b0) else begin
            report_value("hold_o", 0, hold);
            reset_errors++;
        end
        assert (mem_write_enable === '0) else begin
            report_value("mem_write_enable_o", 0, mem_write_enable);
            reset_errors++;
        end
        assert (read_data === '0) else begin
            report_value("read_data_o", 0, read_data);
            reset_errors++;
        end
        reset_n = 1'b1;

        for (int n = 0; n < NUM_OPS; n++) begin
            pick_op();
            run_op();
        end

        $display("Errors: reset %0d, hold %0d, load %0d, store %0d",
                 reset_errors, hold_errors, load_errors, store_errors);
        if (reset_errors + hold_errors + load_errors + store_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/vlsu_pkg.sv
source/vlsu_sequencer.sv
source/vlsu_store_lane.sv
source/vlsu_load_merge.sv
source/vector_lsu.sv
verification/tb_vlsu_memory.sv
verification/tb_vector_lsu.sv
